//--- verilog/geiger_pkg.sv
package geiger_pkg;

    // ------------------------------
    // board and display geometry
    // ------------------------------

    localparam int clk_mhz  = 50;
    localparam int n_tubes  = 2;
    localparam int n_digits = 8;

    // bits per hex digit on the display
    localparam int w_nibble = 4;

    // six digits of particles, two digits of active time
    localparam int w_particle_cnt = 6 * w_nibble;
    localparam int w_time_cnt     = n_digits * w_nibble - w_particle_cnt;

    // ------------------------------
    // vector types
    // ------------------------------

    typedef logic [n_tubes - 1:0]               tube_vec_t;
    typedef logic [$clog2(n_tubes + 1) - 1:0]   tally_t;
    typedef logic [w_particle_cnt - 1:0]        particle_cnt_t;
    typedef logic [w_time_cnt - 1:0]            time_cnt_t;
    typedef logic [n_digits * w_nibble - 1:0]   display_num_t;
    typedef logic [n_digits - 1:0]              digit_vec_t;

    // a b c d e f g h, h is the dot
    typedef logic [7:0]                         segment_t;

    // ------------------------------
    // default timing
    // ------------------------------

    // about 200 ms of visible flash
    localparam int default_flash_cycles = clk_mhz / 5 * 1000 * 1000;

    // time each digit stays lit
    localparam int default_scan_cycles  = 50_000;

endpackage

//--- verilog/tube_input_sync.sv
`timescale 1ns/1ns

module tube_input_sync
(
    input                          clk,
    input                          rst,
    input  geiger_pkg::tube_vec_t  tube_in,
    output geiger_pkg::tube_vec_t  level,
    output geiger_pkg::tube_vec_t  rise,
    output geiger_pkg::tally_t     level_tally,
    output geiger_pkg::tally_t     rise_tally
);

    geiger_pkg::tube_vec_t sync_1;
    geiger_pkg::tube_vec_t level_prev;

    // ------------------------------
    // two-flop synchronizer
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            sync_1 <= '0;
            level  <= '0;
        end
        else
        begin
            sync_1 <= tube_in;
            level  <= sync_1;
        end

    // ------------------------------
    // rising edge, registered strobe
    // ------------------------------

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            level_prev <= '0;
            rise       <= '0;
        end
        else
        begin
            level_prev <= level;
            rise       <= level & ~level_prev;
        end

    // how many tubes are high / just fired this cycle
    always_comb
    begin
        level_tally = '0;
        rise_tally  = '0;

        for (int i = 0; i < geiger_pkg::n_tubes; i++)
        begin
            level_tally += geiger_pkg::tally_t'(level[i]);
            rise_tally  += geiger_pkg::tally_t'(rise[i]);
        end
    end

    // a strobe means the level went 0 then 1 over the two previous cycles
    for (genvar i = 0; i < geiger_pkg::n_tubes; i++)
    begin : g_chk
        assert property (@(posedge clk) disable iff (rst)
            rise[i] |-> $past(level[i]) && !$past(level[i], 2));
    end

endmodule

//--- verilog/particle_counter.sv
`timescale 1ns/1ns

module particle_counter
(
    input                             clk,
    input                             rst,
    input  geiger_pkg::tally_t        level_tally,
    input  geiger_pkg::tally_t        rise_tally,
    output geiger_pkg::display_num_t  number
);

    geiger_pkg::particle_cnt_t particle_cnt;
    geiger_pkg::time_cnt_t     time_cnt;

    // ------------------------------
    // particle count
    // ------------------------------

    // one per rising edge, both tubes may fire together
    always_ff @(posedge clk or posedge rst)
        if (rst)
            particle_cnt <= '0;
        else
            particle_cnt <= particle_cnt + geiger_pkg::particle_cnt_t'(rise_tally);

    // ------------------------------
    // tube-active time
    // ------------------------------

    // summed over both tubes, wraps at 256
    always_ff @(posedge clk or posedge rst)
        if (rst)
            time_cnt <= '0;
        else
            time_cnt <= time_cnt + geiger_pkg::time_cnt_t'(level_tally);

    // time in the top two digits, particles below
    assign number = {time_cnt, particle_cnt};

endmodule

//--- verilog/pulse_stretcher.sv
`timescale 1ns/1ns

module pulse_stretcher
#(
    parameter int flash_cycles = geiger_pkg::default_flash_cycles
)
(
    input                          clk,
    input                          rst,
    input  geiger_pkg::tube_vec_t  rise,
    output geiger_pkg::tube_vec_t  flash
);

    localparam int w_cnt = $clog2(flash_cycles + 1);

    // ------------------------------
    // one retriggerable timer per tube
    // ------------------------------

    for (genvar i = 0; i < geiger_pkg::n_tubes; i++)
    begin : g_tube

        logic [w_cnt - 1:0] cnt;

        // a new particle restarts the full flash
        always_ff @(posedge clk or posedge rst)
            if (rst)
                cnt <= '0;
            else if (rise[i])
                cnt <= w_cnt'(flash_cycles);
            else if (cnt != '0)
                cnt <= cnt - 1'b1;

        assign flash[i] = |cnt;

        assert property (@(posedge clk) disable iff (rst)
            cnt <= w_cnt'(flash_cycles));

    end

endmodule

//--- verilog/seven_segment_display.sv
`timescale 1ns/1ns

module seven_segment_display
#(
    parameter int scan_cycles = geiger_pkg::default_scan_cycles
)
(
    input                             clk,
    input                             rst,
    input  geiger_pkg::display_num_t  number,
    input  geiger_pkg::digit_vec_t    dots,
    output geiger_pkg::segment_t      abcdefgh,
    output geiger_pkg::digit_vec_t    digit
);

    localparam int w_scan  = $clog2(scan_cycles + 1);
    localparam int w_index = $clog2(geiger_pkg::n_digits);

    logic [w_scan - 1:0]  scan_cnt;
    logic                 scan_tick;
    logic [w_index - 1:0] index;
    logic [w_index - 1:0] index_next;
    logic [3:0]           nibble;
    logic [6:0]           glyph;

    // ------------------------------
    // scan prescaler
    // ------------------------------

    assign scan_tick = (scan_cnt == w_scan'(scan_cycles - 1));

    always_ff @(posedge clk or posedge rst)
        if (rst)
            scan_cnt <= '0;
        else if (scan_tick)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;

    // index wraps 7 -> 0 on its own
    assign index_next = scan_tick ? index + 1'b1 : index;

    // digit select kept in step with the index
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            index <= '0;
            digit <= '0;
        end
        else
        begin
            index <= index_next;
            digit <= geiger_pkg::digit_vec_t'(1) << index_next;
        end

    // ------------------------------
    // hex glyphs, a..g
    // ------------------------------

    assign nibble = number[index * geiger_pkg::w_nibble +: geiger_pkg::w_nibble];

    always_comb
        case (nibble)
            4'h0: glyph = 7'b1111110;
            4'h1: glyph = 7'b0110000;
            4'h2: glyph = 7'b1101101;
            4'h3: glyph = 7'b1111001;
            4'h4: glyph = 7'b0110011;
            4'h5: glyph = 7'b1011011;
            4'h6: glyph = 7'b1011111;
            4'h7: glyph = 7'b1110000;
            4'h8: glyph = 7'b1111111;
            4'h9: glyph = 7'b1111011;
            4'ha: glyph = 7'b1110111;
            4'hb: glyph = 7'b0011111;  // lower case b
            4'hc: glyph = 7'b1001110;
            4'hd: glyph = 7'b0111101;  // lower case d
            4'he: glyph = 7'b1001111;
            default: glyph = 7'b1000111;
        endcase

    // dark until the scanner has selected a digit
    assign abcdefgh = (|digit) ? {glyph, dots[index]} : '0;

    assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> $onehot(digit));

endmodule

//--- verilog/geiger_top.sv
`timescale 1ns/1ns

module geiger_top
#(
    parameter int flash_cycles = geiger_pkg::default_flash_cycles,
    parameter int scan_cycles  = geiger_pkg::default_scan_cycles
)
(
    input                          clk,
    input                          rst,
    input  geiger_pkg::tube_vec_t  tube_in,
    output logic [7:0]             led,
    output geiger_pkg::segment_t   abcdefgh,
    output geiger_pkg::digit_vec_t digit
);

    geiger_pkg::tube_vec_t    rise;
    geiger_pkg::tally_t       level_tally;
    geiger_pkg::tally_t       rise_tally;
    geiger_pkg::display_num_t number;
    geiger_pkg::tube_vec_t    flash;
    geiger_pkg::digit_vec_t   dots;

    // ------------------------------
    // tube front end and counters
    // ------------------------------

    // the level itself is only needed for the tally
    tube_input_sync i_sync
    (
        .clk         (clk),
        .rst         (rst),
        .tube_in     (tube_in),
        .level       (),
        .rise        (rise),
        .level_tally (level_tally),
        .rise_tally  (rise_tally)
    );

    particle_counter i_counter
    (
        .clk         (clk),
        .rst         (rst),
        .level_tally (level_tally),
        .rise_tally  (rise_tally),
        .number      (number)
    );

    // ------------------------------
    // flash and display
    // ------------------------------

    pulse_stretcher #(.flash_cycles(flash_cycles)) i_stretch
    (
        .clk   (clk),
        .rst   (rst),
        .rise  (rise),
        .flash (flash)
    );

    // tube 0 on even positions, tube 1 on odd
    assign led  = {(8 / geiger_pkg::n_tubes){flash}};
    assign dots = {(geiger_pkg::n_digits / geiger_pkg::n_tubes){flash}};

    seven_segment_display #(.scan_cycles(scan_cycles)) i_display
    (
        .clk      (clk),
        .rst      (rst),
        .number   (number),
        .dots     (dots),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

//--- verif/tb_geiger.sv
`timescale 1ns/1ns

module tb_geiger;

    typedef struct packed
    {
        bit         rnd;
        logic [1:0] pattern;
        logic [7:0] high;
        logic [7:0] low;
        logic [7:0] reps;
    } stim_t;

    logic                      clk;
    logic                      rst;
    geiger_pkg::tube_vec_t     tube_in;
    logic [7:0]                led;
    geiger_pkg::segment_t      abcdefgh;
    geiger_pkg::digit_vec_t    digit;

    stim_t       stim [0:5];
    logic [23:0] exp_particle;
    logic [7:0]  exp_time;
    logic [1:0]  tube_prev;
    logic [31:0] rand_state;
    int          errors;
    int          checks;
    int          cycles;
    int          cycle_limit = 2000;

    geiger_top #(.flash_cycles(20), .scan_cycles(4)) dut
    (
        .clk      (clk),
        .rst      (rst),
        .tube_in  (tube_in),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > cycle_limit)
        begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // standard hex glyphs, a..g, valid flag in bit 4
    function automatic logic [4:0] glyph_to_nibble(input logic [6:0] g);
        case (g)
            7'b1111110: return 5'h10;
            7'b0110000: return 5'h11;
            7'b1101101: return 5'h12;
            7'b1111001: return 5'h13;
            7'b0110011: return 5'h14;
            7'b1011011: return 5'h15;
            7'b1011111: return 5'h16;
            7'b1110000: return 5'h17;
            7'b1111111: return 5'h18;
            7'b1111011: return 5'h19;
            7'b1110111: return 5'h1a;
            7'b0011111: return 5'h1b;
            7'b1001110: return 5'h1c;
            7'b0111101: return 5'h1d;
            7'b1001111: return 5'h1e;
            7'b1000111: return 5'h1f;
            default:    return 5'h00;
        endcase
    endfunction

    // position of the single lit digit, -1 if not one-hot
    function automatic int digit_position(input logic [7:0] d);
        int pos;
        pos = -1;
        for (int b = 0; b < 8; b++)
            if (d === 8'(1 << b))
                pos = b;
        return pos;
    endfunction

    // ------------------------------
    // stimulus and reference model
    // ------------------------------

    // one clock of input, counted as the tubes would see it
    task automatic drive_cycle(input logic [1:0] pattern);
        tube_in = pattern;
        for (int t = 0; t < 2; t++)
        begin
            if (pattern[t] && !tube_prev[t])
                exp_particle = exp_particle + 24'd1;
            if (pattern[t])
                exp_time = exp_time + 8'd1;
        end
        tube_prev = pattern;
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) drive_cycle(2'b00);
    endtask

    task automatic apply_entry(input int k);
        logic [1:0] pat;
        for (int r = 0; r < int'(stim[k].reps); r++)
        begin
            pat = stim[k].pattern;
            if (stim[k].rnd)
            begin
                rand_state = lcg_next(rand_state);
                pat = rand_state[17:16];
            end
            repeat (int'(stim[k].high)) drive_cycle(pat);
            repeat (int'(stim[k].low)) drive_cycle(2'b00);
        end
    endtask

    // ------------------------------
    // display readout
    // ------------------------------

    task automatic read_display(output logic [31:0] value);
        logic [7:0] prev;
        logic [4:0] dec;
        value = '0;
        @(negedge clk);
        while (digit !== 8'h80)
            @(negedge clk);
        prev = digit;
        for (int i = 0; i < 8; i++)
        begin
            while (digit === prev)
                @(negedge clk);
            prev = digit;
            checks++;
            assert (digit === 8'(1 << i))
            else
            begin
                errors++;
                $display("Error: digit = %h, expected %h", digit, 8'(1 << i));
            end
            dec = glyph_to_nibble(abcdefgh[7:1]);
            checks++;
            assert (dec[4])
            else
            begin
                errors++;
                $display("Segments %h on digit %0d are not a hex glyph", abcdefgh, i);
            end
            value[i * 4 +: 4] = dec[3:0];
            checks++;
            assert (abcdefgh[0] === led[i % 2])
            else
            begin
                errors++;
                $display("Error: abcdefgh[0] = %h, expected %h", abcdefgh[0], led[i % 2]);
            end
        end
        // back onto the drive point
        @(posedge clk);
        #1;
    endtask

    task automatic check_display();
        logic [31:0] value;
        idle(6);
        read_display(value);
        checks++;
        assert (value === {exp_time, exp_particle})
        else
        begin
            errors++;
            $display("Error: number = %h, expected %h", value, {exp_time, exp_particle});
        end
    endtask

    // one pulse at cycle 0, a retrigger at gap when gap is nonzero
    task automatic check_flash(input int tube, input int gap);
        logic [7:0] mask;
        logic [1:0] pat;
        int         since;
        int         set_at;
        int         pos;
        bit         cleared;
        mask = (tube == 0) ? 8'h55 : 8'haa;
        pat = 2'b00;
        pat[tube] = 1'b1;
        since = 0;
        set_at = -1;
        cleared = 0;
        for (int k = 0; k < gap + 32; k++)
        begin
            if (k == 0 || k == gap)
            begin
                drive_cycle(pat);
                since = 1;
            end
            else
            begin
                drive_cycle(2'b00);
                since++;
            end
            if (set_at < 0 && (led & mask) !== 8'h00)
                set_at = k + 1;
            checks++;
            assert ((led & mask) === 8'h00 || (led & mask) === mask)
            else
            begin
                errors++;
                $display("Error: led = %h, expected all or none of %h", led, mask);
            end
            // the lit digit carries the dot of tube pos mod 2
            pos = digit_position(digit);
            checks++;
            assert (pos >= 0 && abcdefgh[0] === led[pos % 2])
            else
            begin
                errors++;
                $display("Error: abcdefgh[0] = %h, expected %h on digit %0d",
                         abcdefgh[0], led[pos % 2], pos);
            end
            if (set_at >= 0 && !cleared && (led & mask) === 8'h00)
            begin
                cleared = 1;
                checks++;
                assert (k >= gap && since >= 20 && since <= 26)
                else
                begin
                    errors++;
                    $display("Tube %0d flash ended %0d cycles after its last rise", tube, since);
                end
            end
        end
        checks++;
        assert (set_at >= 1 && set_at <= 6 && cleared)
        else
        begin
            errors++;
            $display("Tube %0d flash did not light within 6 cycles and then clear", tube);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        tube_in = '0;
        tube_prev = '0;
        exp_particle = '0;
        exp_time = '0;
        rand_state = 32'd31;
        errors = 0;
        checks = 0;
        cycles = 0;

        // pattern, high, low, repeats; the last one is random
        stim[0] = '{1'b0, 2'b01, 8'd1, 8'd5, 8'd5};
        stim[1] = '{1'b0, 2'b10, 8'd2, 8'd5, 8'd7};
        stim[2] = '{1'b0, 2'b11, 8'd1, 8'd4, 8'd6};
        stim[3] = '{1'b0, 2'b01, 8'd40, 8'd5, 8'd1};
        stim[4] = '{1'b0, 2'b11, 8'd150, 8'd5, 8'd1};
        stim[5] = '{1'b1, 2'b00, 8'd2, 8'd1, 8'd64};
        for (int k = 0; k < 6; k++)
            cycle_limit += (int'(stim[k].high) + int'(stim[k].low)) * int'(stim[k].reps);

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        checks++;
        assert ($onehot(digit) && led === 8'h00)
        else
        begin
            errors++;
            $display("Error: digit = %h, led = %h after reset", digit, led);
        end
        check_display();

        for (int k = 0; k < 6; k++)
        begin
            apply_entry(k);
            check_display();
        end

        idle(30);
        check_flash(0, 0);
        check_flash(1, 0);
        check_flash(0, 10);
        check_display();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tb.f
verilog/geiger_pkg.sv
verilog/tube_input_sync.sv
verilog/particle_counter.sv
verilog/pulse_stretcher.sv
verilog/seven_segment_display.sv
verilog/geiger_top.sv
verif/tb_geiger.sv

//--- Makefile
# Verilator build and run for the Geiger counter testbench

VERILATOR ?= verilator
TOP       ?= tb_geiger
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || \
		{ echo "run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
